// File: source/buf_pkg.sv
// widths, depths and address types for the shared cnn/lidar buffers
// every address carries the ping-pong tag in its top bit
// a row always holds 2**lane_w memory-bus words
// write address is {tag, row, lane}, read address is {tag, row}
package buf_pkg;

  // memory-bus word
  localparam int MEM_W = 32;

  // ping-pong tag, one bit selects the half
  localparam int TAG_W = 1;

  // read address widths, tag included
  // ibuf 16 rows per tag, wbuf 8, bbuf 4
  localparam int IBUF_ROW_ADDR_W = TAG_W + 4;
  localparam int WBUF_ROW_ADDR_W = TAG_W + 3;
  localparam int BBUF_ROW_ADDR_W = TAG_W + 2;

  // lane select widths
  localparam int IBUF_LANE_W = 1;
  localparam int WBUF_LANE_W = 2;
  localparam int BBUF_LANE_W = 1;

  // one bus word
  typedef logic [MEM_W-1:0] mem_word_t;

  // full rows, lane 0 in the low word
  typedef logic [(2**IBUF_LANE_W)*MEM_W-1:0] ibuf_row_t;
  typedef logic [(2**WBUF_LANE_W)*MEM_W-1:0] wbuf_row_t;
  typedef logic [(2**BBUF_LANE_W)*MEM_W-1:0] bbuf_row_t;

  // write addresses
  typedef logic [IBUF_ROW_ADDR_W+IBUF_LANE_W-1:0] ibuf_waddr_t;
  typedef logic [WBUF_ROW_ADDR_W+WBUF_LANE_W-1:0] wbuf_waddr_t;
  typedef logic [BBUF_ROW_ADDR_W+BBUF_LANE_W-1:0] bbuf_waddr_t;

  // read addresses
  typedef logic [IBUF_ROW_ADDR_W-1:0] ibuf_raddr_t;
  typedef logic [WBUF_ROW_ADDR_W-1:0] wbuf_raddr_t;
  typedef logic [BBUF_ROW_ADDR_W-1:0] bbuf_raddr_t;

endpackage

// File: source/client_mux.sv
// steers either the cnn or the lidar request set onto all three buffers
// purely combinational, sel_cnn high picks cnn, low picks lidar
// requests of the client not selected are dropped here
`timescale 1ns/100ps

module client_mux (
  input  logic                 sel_cnn,

  // ibuf requests
  input  buf_pkg::ibuf_waddr_t cnn_ibuf_write_addr,
  input  buf_pkg::ibuf_waddr_t lidar_ibuf_write_addr,
  input  logic                 cnn_ibuf_write_req,
  input  logic                 lidar_ibuf_write_req,
  input  buf_pkg::mem_word_t   cnn_ibuf_write_data,
  input  buf_pkg::mem_word_t   lidar_ibuf_write_data,
  input  buf_pkg::ibuf_raddr_t cnn_ibuf_read_addr,
  input  buf_pkg::ibuf_raddr_t lidar_ibuf_read_addr,
  input  logic                 cnn_ibuf_read_req,
  input  logic                 lidar_ibuf_read_req,

  // wbuf requests
  input  buf_pkg::wbuf_waddr_t cnn_wbuf_write_addr,
  input  buf_pkg::wbuf_waddr_t lidar_wbuf_write_addr,
  input  logic                 cnn_wbuf_write_req,
  input  logic                 lidar_wbuf_write_req,
  input  buf_pkg::mem_word_t   cnn_wbuf_write_data,
  input  buf_pkg::mem_word_t   lidar_wbuf_write_data,
  input  buf_pkg::wbuf_raddr_t cnn_wbuf_read_addr,
  input  buf_pkg::wbuf_raddr_t lidar_wbuf_read_addr,
  input  logic                 cnn_wbuf_read_req,
  input  logic                 lidar_wbuf_read_req,

  // bbuf requests
  input  buf_pkg::bbuf_waddr_t cnn_bbuf_write_addr,
  input  buf_pkg::bbuf_waddr_t lidar_bbuf_write_addr,
  input  logic                 cnn_bbuf_write_req,
  input  logic                 lidar_bbuf_write_req,
  input  buf_pkg::mem_word_t   cnn_bbuf_write_data,
  input  buf_pkg::mem_word_t   lidar_bbuf_write_data,
  input  buf_pkg::bbuf_raddr_t cnn_bbuf_read_addr,
  input  buf_pkg::bbuf_raddr_t lidar_bbuf_read_addr,
  input  logic                 cnn_bbuf_read_req,
  input  logic                 lidar_bbuf_read_req,

  // selected set, one per buffer
  output buf_pkg::ibuf_waddr_t ibuf_write_addr,
  output logic                 ibuf_write_req,
  output buf_pkg::mem_word_t   ibuf_write_data,
  output buf_pkg::ibuf_raddr_t ibuf_read_addr,
  output logic                 ibuf_read_req,

  output buf_pkg::wbuf_waddr_t wbuf_write_addr,
  output logic                 wbuf_write_req,
  output buf_pkg::mem_word_t   wbuf_write_data,
  output buf_pkg::wbuf_raddr_t wbuf_read_addr,
  output logic                 wbuf_read_req,

  output buf_pkg::bbuf_waddr_t bbuf_write_addr,
  output logic                 bbuf_write_req,
  output buf_pkg::mem_word_t   bbuf_write_data,
  output buf_pkg::bbuf_raddr_t bbuf_read_addr,
  output logic                 bbuf_read_req
);

  // ibuf
  assign ibuf_write_addr = sel_cnn ? cnn_ibuf_write_addr : lidar_ibuf_write_addr;
  assign ibuf_write_req  = sel_cnn ? cnn_ibuf_write_req  : lidar_ibuf_write_req;
  assign ibuf_write_data = sel_cnn ? cnn_ibuf_write_data : lidar_ibuf_write_data;
  assign ibuf_read_addr  = sel_cnn ? cnn_ibuf_read_addr  : lidar_ibuf_read_addr;
  assign ibuf_read_req   = sel_cnn ? cnn_ibuf_read_req   : lidar_ibuf_read_req;

  // wbuf
  assign wbuf_write_addr = sel_cnn ? cnn_wbuf_write_addr : lidar_wbuf_write_addr;
  assign wbuf_write_req  = sel_cnn ? cnn_wbuf_write_req  : lidar_wbuf_write_req;
  assign wbuf_write_data = sel_cnn ? cnn_wbuf_write_data : lidar_wbuf_write_data;
  assign wbuf_read_addr  = sel_cnn ? cnn_wbuf_read_addr  : lidar_wbuf_read_addr;
  assign wbuf_read_req   = sel_cnn ? cnn_wbuf_read_req   : lidar_wbuf_read_req;

  // bbuf
  assign bbuf_write_addr = sel_cnn ? cnn_bbuf_write_addr : lidar_bbuf_write_addr;
  assign bbuf_write_req  = sel_cnn ? cnn_bbuf_write_req  : lidar_bbuf_write_req;
  assign bbuf_write_data = sel_cnn ? cnn_bbuf_write_data : lidar_bbuf_write_data;
  assign bbuf_read_addr  = sel_cnn ? cnn_bbuf_read_addr  : lidar_bbuf_read_addr;
  assign bbuf_read_req   = sel_cnn ? cnn_bbuf_read_req   : lidar_bbuf_read_req;

endmodule

// File: source/row_buf.sv
// row buffer, written one bus word per lane and read a whole row at a time
// row_t must be 2**LANE_W bus words wide
// read data is registered, valid one cycle after read_req, held otherwise
// a read and a write to one row on the same edge return the old row
// memory contents are not cleared by rst, only read_data is
`timescale 1ns/100ps

module row_buf #(
  parameter type row_t      = logic [63:0],
  parameter int  ROW_ADDR_W = 5,
  parameter int  LANE_W     = 1
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [ROW_ADDR_W+LANE_W-1:0] write_addr,
  input  logic                         write_req,
  input  buf_pkg::mem_word_t           write_data,
  input  logic [ROW_ADDR_W-1:0]        read_addr,
  input  logic                         read_req,
  output row_t                         read_data
);

  import buf_pkg::*;

  // rows per buffer, both tag halves together
  localparam int DEPTH = 2**ROW_ADDR_W;
  localparam int ROW_W = $bits(row_t);

  // storage, one entry per row
  logic [ROW_W-1:0] mem [DEPTH];

  // write address split
  // upper bits pick the row (tag on top), low bits pick the lane
  logic [ROW_ADDR_W-1:0] wr_row;
  logic [LANE_W-1:0]     wr_lane;

  assign wr_row  = write_addr[ROW_ADDR_W+LANE_W-1:LANE_W];
  assign wr_lane = write_addr[LANE_W-1:0];

  // lane write, other lanes of the row untouched
  always_ff @(posedge clk) begin
    if (write_req) begin
      mem[wr_row][int'(wr_lane)*MEM_W +: MEM_W] <= write_data;
    end
  end

  // registered row read
  // nonblocking, so same-edge write is not seen yet
  always_ff @(posedge clk) begin
    if (rst) begin
      read_data <= '0;
    end else if (read_req) begin
      read_data <= row_t'(mem[read_addr]);
    end
  end

endmodule

// File: source/shared_bufs.sv
// ibuf, wbuf and bbuf shared by a cnn and a lidar client
// sel_cnn picks the owner, sampled with the requests at the same edge
// read latency is one cycle, no back-pressure, every request accepted
// each read_data goes to whichever client is listening
`timescale 1ns/100ps

module shared_bufs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sel_cnn,

  // cnn client
  input  buf_pkg::ibuf_waddr_t cnn_ibuf_write_addr,
  input  logic                 cnn_ibuf_write_req,
  input  buf_pkg::mem_word_t   cnn_ibuf_write_data,
  input  buf_pkg::ibuf_raddr_t cnn_ibuf_read_addr,
  input  logic                 cnn_ibuf_read_req,
  input  buf_pkg::wbuf_waddr_t cnn_wbuf_write_addr,
  input  logic                 cnn_wbuf_write_req,
  input  buf_pkg::mem_word_t   cnn_wbuf_write_data,
  input  buf_pkg::wbuf_raddr_t cnn_wbuf_read_addr,
  input  logic                 cnn_wbuf_read_req,
  input  buf_pkg::bbuf_waddr_t cnn_bbuf_write_addr,
  input  logic                 cnn_bbuf_write_req,
  input  buf_pkg::mem_word_t   cnn_bbuf_write_data,
  input  buf_pkg::bbuf_raddr_t cnn_bbuf_read_addr,
  input  logic                 cnn_bbuf_read_req,

  // lidar client
  input  buf_pkg::ibuf_waddr_t lidar_ibuf_write_addr,
  input  logic                 lidar_ibuf_write_req,
  input  buf_pkg::mem_word_t   lidar_ibuf_write_data,
  input  buf_pkg::ibuf_raddr_t lidar_ibuf_read_addr,
  input  logic                 lidar_ibuf_read_req,
  input  buf_pkg::wbuf_waddr_t lidar_wbuf_write_addr,
  input  logic                 lidar_wbuf_write_req,
  input  buf_pkg::mem_word_t   lidar_wbuf_write_data,
  input  buf_pkg::wbuf_raddr_t lidar_wbuf_read_addr,
  input  logic                 lidar_wbuf_read_req,
  input  buf_pkg::bbuf_waddr_t lidar_bbuf_write_addr,
  input  logic                 lidar_bbuf_write_req,
  input  buf_pkg::mem_word_t   lidar_bbuf_write_data,
  input  buf_pkg::bbuf_raddr_t lidar_bbuf_read_addr,
  input  logic                 lidar_bbuf_read_req,

  // row read data, one port per buffer
  output buf_pkg::ibuf_row_t   ibuf_read_data,
  output buf_pkg::wbuf_row_t   wbuf_read_data,
  output buf_pkg::bbuf_row_t   bbuf_read_data
);

  import buf_pkg::*;

  // selected requests, mux to buffers
  ibuf_waddr_t ibuf_write_addr;
  logic        ibuf_write_req;
  mem_word_t   ibuf_write_data;
  ibuf_raddr_t ibuf_read_addr;
  logic        ibuf_read_req;

  wbuf_waddr_t wbuf_write_addr;
  logic        wbuf_write_req;
  mem_word_t   wbuf_write_data;
  wbuf_raddr_t wbuf_read_addr;
  logic        wbuf_read_req;

  bbuf_waddr_t bbuf_write_addr;
  logic        bbuf_write_req;
  mem_word_t   bbuf_write_data;
  bbuf_raddr_t bbuf_read_addr;
  logic        bbuf_read_req;

  // client select, zero latency
  client_mux u_mux (
    .sel_cnn               (sel_cnn),
    .cnn_ibuf_write_addr   (cnn_ibuf_write_addr),
    .lidar_ibuf_write_addr (lidar_ibuf_write_addr),
    .cnn_ibuf_write_req    (cnn_ibuf_write_req),
    .lidar_ibuf_write_req  (lidar_ibuf_write_req),
    .cnn_ibuf_write_data   (cnn_ibuf_write_data),
    .lidar_ibuf_write_data (lidar_ibuf_write_data),
    .cnn_ibuf_read_addr    (cnn_ibuf_read_addr),
    .lidar_ibuf_read_addr  (lidar_ibuf_read_addr),
    .cnn_ibuf_read_req     (cnn_ibuf_read_req),
    .lidar_ibuf_read_req   (lidar_ibuf_read_req),
    .cnn_wbuf_write_addr   (cnn_wbuf_write_addr),
    .lidar_wbuf_write_addr (lidar_wbuf_write_addr),
    .cnn_wbuf_write_req    (cnn_wbuf_write_req),
    .lidar_wbuf_write_req  (lidar_wbuf_write_req),
    .cnn_wbuf_write_data   (cnn_wbuf_write_data),
    .lidar_wbuf_write_data (lidar_wbuf_write_data),
    .cnn_wbuf_read_addr    (cnn_wbuf_read_addr),
    .lidar_wbuf_read_addr  (lidar_wbuf_read_addr),
    .cnn_wbuf_read_req     (cnn_wbuf_read_req),
    .lidar_wbuf_read_req   (lidar_wbuf_read_req),
    .cnn_bbuf_write_addr   (cnn_bbuf_write_addr),
    .lidar_bbuf_write_addr (lidar_bbuf_write_addr),
    .cnn_bbuf_write_req    (cnn_bbuf_write_req),
    .lidar_bbuf_write_req  (lidar_bbuf_write_req),
    .cnn_bbuf_write_data   (cnn_bbuf_write_data),
    .lidar_bbuf_write_data (lidar_bbuf_write_data),
    .cnn_bbuf_read_addr    (cnn_bbuf_read_addr),
    .lidar_bbuf_read_addr  (lidar_bbuf_read_addr),
    .cnn_bbuf_read_req     (cnn_bbuf_read_req),
    .lidar_bbuf_read_req   (lidar_bbuf_read_req),
    .ibuf_write_addr       (ibuf_write_addr),
    .ibuf_write_req        (ibuf_write_req),
    .ibuf_write_data       (ibuf_write_data),
    .ibuf_read_addr        (ibuf_read_addr),
    .ibuf_read_req         (ibuf_read_req),
    .wbuf_write_addr       (wbuf_write_addr),
    .wbuf_write_req        (wbuf_write_req),
    .wbuf_write_data       (wbuf_write_data),
    .wbuf_read_addr        (wbuf_read_addr),
    .wbuf_read_req         (wbuf_read_req),
    .bbuf_write_addr       (bbuf_write_addr),
    .bbuf_write_req        (bbuf_write_req),
    .bbuf_write_data       (bbuf_write_data),
    .bbuf_read_addr        (bbuf_read_addr),
    .bbuf_read_req         (bbuf_read_req)
  );

  // input buffer, 2 words per row
  row_buf #(
    .row_t      (ibuf_row_t),
    .ROW_ADDR_W (IBUF_ROW_ADDR_W),
    .LANE_W     (IBUF_LANE_W)
  ) ibuf_ram (
    .clk        (clk),
    .rst        (rst),
    .write_addr (ibuf_write_addr),
    .write_req  (ibuf_write_req),
    .write_data (ibuf_write_data),
    .read_addr  (ibuf_read_addr),
    .read_req   (ibuf_read_req),
    .read_data  (ibuf_read_data)
  );

  // weight buffer, 4 words per row
  row_buf #(
    .row_t      (wbuf_row_t),
    .ROW_ADDR_W (WBUF_ROW_ADDR_W),
    .LANE_W     (WBUF_LANE_W)
  ) wbuf_ram (
    .clk        (clk),
    .rst        (rst),
    .write_addr (wbuf_write_addr),
    .write_req  (wbuf_write_req),
    .write_data (wbuf_write_data),
    .read_addr  (wbuf_read_addr),
    .read_req   (wbuf_read_req),
    .read_data  (wbuf_read_data)
  );

  // bias buffer, 2 words per row
  row_buf #(
    .row_t      (bbuf_row_t),
    .ROW_ADDR_W (BBUF_ROW_ADDR_W),
    .LANE_W     (BBUF_LANE_W)
  ) bbuf_ram (
    .clk        (clk),
    .rst        (rst),
    .write_addr (bbuf_write_addr),
    .write_req  (bbuf_write_req),
    .write_data (bbuf_write_data),
    .read_addr  (bbuf_read_addr),
    .read_req   (bbuf_read_req),
    .read_data  (bbuf_read_data)
  );

endmodule

// File: dv/tb_clk_gen.sv
// testbench clock with a 4 ns period and a synchronous reset
// rst is high over the first 2 rising edges, released on a falling edge
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release after two rising edges
  initial begin
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

// File: dv/shared_bufs_asserts.sv
// checks on the registered read outputs of shared_bufs
// bound into the top level, sees the muxed read requests inside it
`timescale 1ns/100ps

module shared_bufs_asserts (
  input logic               clk,
  input logic               rst,
  input logic               ibuf_read_req,
  input logic               wbuf_read_req,
  input logic               bbuf_read_req,
  input buf_pkg::ibuf_row_t ibuf_read_data,
  input buf_pkg::wbuf_row_t wbuf_read_data,
  input buf_pkg::bbuf_row_t bbuf_read_data
);

  // an output moves only after a request on the edge before
  a_ibuf_hold : assert property (@(posedge clk) disable iff (rst)
    !$stable(ibuf_read_data) |-> $past(ibuf_read_req) || $past(rst))
    else $error("ibuf_read_data changed without a read request");

  a_wbuf_hold : assert property (@(posedge clk) disable iff (rst)
    !$stable(wbuf_read_data) |-> $past(wbuf_read_req) || $past(rst))
    else $error("wbuf_read_data changed without a read request");

  a_bbuf_hold : assert property (@(posedge clk) disable iff (rst)
    !$stable(bbuf_read_data) |-> $past(bbuf_read_req) || $past(rst))
    else $error("bbuf_read_data changed without a read request");

  // reset clears all three outputs
  a_rst_clear : assert property (@(posedge clk)
    $past(rst) |-> ibuf_read_data == '0 && wbuf_read_data == '0 && bbuf_read_data == '0)
    else $error("read data not zero in the cycle after reset");

endmodule

bind shared_bufs shared_bufs_asserts u_asserts (
  .clk            (clk),
  .rst            (rst),
  .ibuf_read_req  (ibuf_read_req),
  .wbuf_read_req  (wbuf_read_req),
  .bbuf_read_req  (bbuf_read_req),
  .ibuf_read_data (ibuf_read_data),
  .wbuf_read_data (wbuf_read_data),
  .bbuf_read_data (bbuf_read_data)
);

// File: dv/tb_shared_bufs.sv
// table-driven testbench for the shared cnn/lidar buffers
// inputs change on the falling edge and each result is sampled one cycle later
// a model per buffer follows the lane write and row read rules
// only rows with every lane written are read, memory is never cleared
`timescale 1ns/100ps

module tb_shared_bufs;

  import buf_pkg::*;

  // buffer, operation and client codes of a table entry
  localparam logic [1:0] IBUF    = 2'd0;
  localparam logic [1:0] WBUF    = 2'd1;
  localparam logic [1:0] BBUF    = 2'd2;
  localparam logic [1:0] OP_NONE = 2'b00;
  localparam logic [1:0] OP_WR   = 2'b01;
  localparam logic [1:0] OP_RD   = 2'b10;
  localparam logic [1:0] OP_WRRD = 2'b11;
  localparam logic       CNN     = 1'b0;
  localparam logic       LIDAR   = 1'b1;

  // one table entry
  // addr is {tag, row, lane}
  // exp_row sized for the widest row
  // ibuf and bbuf use only its low bits
  typedef struct packed {
    logic       sel_cnn;
    logic       client;
    logic [1:0] bsel;
    logic [1:0] op;
    logic [5:0] addr;
    mem_word_t  data;
    wbuf_row_t  exp_row;
  } step_t;

  logic        clk, rst, sel_cnn;
  ibuf_waddr_t cnn_ibuf_write_addr, lidar_ibuf_write_addr;
  wbuf_waddr_t cnn_wbuf_write_addr, lidar_wbuf_write_addr;
  bbuf_waddr_t cnn_bbuf_write_addr, lidar_bbuf_write_addr;
  ibuf_raddr_t cnn_ibuf_read_addr, lidar_ibuf_read_addr;
  wbuf_raddr_t cnn_wbuf_read_addr, lidar_wbuf_read_addr;
  bbuf_raddr_t cnn_bbuf_read_addr, lidar_bbuf_read_addr;
  mem_word_t   cnn_ibuf_write_data, lidar_ibuf_write_data;
  mem_word_t   cnn_wbuf_write_data, lidar_wbuf_write_data;
  mem_word_t   cnn_bbuf_write_data, lidar_bbuf_write_data;
  logic        cnn_ibuf_write_req, lidar_ibuf_write_req, cnn_ibuf_read_req, lidar_ibuf_read_req;
  logic        cnn_wbuf_write_req, lidar_wbuf_write_req, cnn_wbuf_read_req, lidar_wbuf_read_req;
  logic        cnn_bbuf_write_req, lidar_bbuf_write_req, cnn_bbuf_read_req, lidar_bbuf_read_req;
  ibuf_row_t   ibuf_read_data;
  wbuf_row_t   wbuf_read_data;
  bbuf_row_t   bbuf_read_data;

  // model rows per buffer and the value each read_data should hold
  wbuf_row_t   model_mem [3][32];
  wbuf_row_t   model_held [3];
  step_t       steps [$];
  logic [31:0] lcg_state;
  int          cur_step;
  int          cycle_count = 0;

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  shared_bufs dut (.*);

  function automatic mem_word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  // new entry with data from the lcg
  // expected row comes from the model
  task automatic add_step(input logic sel, input logic client, input logic [1:0] bsel,
                          input logic [1:0] op, input logic [5:0] addr);
    step_t      s;
    int         lane_w;
    logic [4:0] row;
    logic [1:0] lane;
    s.sel_cnn = sel;
    s.client  = client;
    s.bsel    = bsel;
    s.op      = op;
    s.addr    = addr;
    s.data    = next_rand();
    lane_w    = (bsel == WBUF) ? 2 : 1;
    row       = 5'(addr >> lane_w);
    lane      = 2'(addr & ((6'd1 << lane_w) - 6'd1));
    // requests count only from the client that owns the buffers
    if (sel == (client == CNN)) begin
      // read first, so a same-edge write is not seen
      if (op[1]) begin
        model_held[bsel] = model_mem[bsel][row];
      end
      if (op[0]) begin
        model_mem[bsel][row][int'(lane)*MEM_W +: MEM_W] = s.data;
      end
    end
    s.exp_row = model_held[bsel];
    steps.push_back(s);
  endtask

  task automatic build_table();
    // cnn fills ibuf row 3, reads it, then the output holds
    add_step(1'b1, CNN, IBUF, OP_WR, 6'h06);
    add_step(1'b1, CNN, IBUF, OP_WR, 6'h07);
    add_step(1'b1, CNN, IBUF, OP_RD, 6'h06);
    add_step(1'b1, CNN, IBUF, OP_NONE, 6'h00);
    add_step(1'b1, CNN, IBUF, OP_NONE, 6'h00);
    // lidar locked out while cnn owns the buffers
    add_step(1'b1, LIDAR, IBUF, OP_WR, 6'h06);
    add_step(1'b1, LIDAR, IBUF, OP_RD, 6'h10);
    add_step(1'b1, CNN, IBUF, OP_RD, 6'h06);
    // ownership moves to lidar
    add_step(1'b0, LIDAR, IBUF, OP_WR, 6'h07);
    add_step(1'b0, CNN, IBUF, OP_WR, 6'h06);
    add_step(1'b0, LIDAR, IBUF, OP_RD, 6'h06);
    // wbuf row 5 under tag 1 is filled and then rewritten one lane at a time
    for (int l = 0; l < 4; l++) begin
      add_step(1'b0, LIDAR, WBUF, OP_WR, 6'h34 + 6'(l));
    end
    add_step(1'b0, LIDAR, WBUF, OP_RD, 6'h34);
    for (int l = 0; l < 4; l++) begin
      add_step(1'b1, CNN, WBUF, OP_WR, 6'h34 + 6'(l));
      add_step(1'b1, CNN, WBUF, OP_RD, 6'h34);
    end
    // bbuf row 2 under tag 0 and tag 1
    add_step(1'b1, CNN, BBUF, OP_WR, 6'h04);
    add_step(1'b1, CNN, BBUF, OP_WR, 6'h05);
    add_step(1'b1, CNN, BBUF, OP_WR, 6'h0c);
    add_step(1'b1, CNN, BBUF, OP_WR, 6'h0d);
    add_step(1'b1, CNN, BBUF, OP_RD, 6'h04);
    add_step(1'b1, CNN, BBUF, OP_RD, 6'h0c);
    add_step(1'b0, LIDAR, BBUF, OP_WR, 6'h0c);
    add_step(1'b0, LIDAR, BBUF, OP_RD, 6'h04);
    add_step(1'b0, LIDAR, BBUF, OP_RD, 6'h0c);
    // same row written and read on one edge
    add_step(1'b0, LIDAR, IBUF, OP_WRRD, 6'h06);
    add_step(1'b0, LIDAR, IBUF, OP_RD, 6'h06);
    add_step(1'b1, CNN, WBUF, OP_WRRD, 6'h36);
    add_step(1'b1, CNN, WBUF, OP_RD, 6'h34);
  endtask

  // drives every dut input for one entry
  task automatic apply_step(input step_t s);
    logic       cnn_on;
    logic       lidar_on;
    logic [5:0] cnn_addr;
    logic [5:0] lidar_addr;
    mem_word_t  cnn_data;
    mem_word_t  lidar_data;
    cnn_on     = (s.client == CNN);
    lidar_on   = (s.client == LIDAR);
    // the idle client gets inverted address and data
    cnn_addr   = cnn_on ? s.addr : ~s.addr;
    lidar_addr = lidar_on ? s.addr : ~s.addr;
    cnn_data   = cnn_on ? s.data : ~s.data;
    lidar_data = lidar_on ? s.data : ~s.data;
    sel_cnn    = s.sel_cnn;
    cnn_ibuf_write_addr   = cnn_addr;
    cnn_ibuf_write_data   = cnn_data;
    cnn_ibuf_read_addr    = cnn_addr[5:1];
    cnn_ibuf_write_req    = cnn_on && s.bsel == IBUF && s.op[0];
    cnn_ibuf_read_req     = cnn_on && s.bsel == IBUF && s.op[1];
    cnn_wbuf_write_addr   = cnn_addr;
    cnn_wbuf_write_data   = cnn_data;
    cnn_wbuf_read_addr    = cnn_addr[5:2];
    cnn_wbuf_write_req    = cnn_on && s.bsel == WBUF && s.op[0];
    cnn_wbuf_read_req     = cnn_on && s.bsel == WBUF && s.op[1];
    cnn_bbuf_write_addr   = cnn_addr[3:0];
    cnn_bbuf_write_data   = cnn_data;
    cnn_bbuf_read_addr    = cnn_addr[3:1];
    cnn_bbuf_write_req    = cnn_on && s.bsel == BBUF && s.op[0];
    cnn_bbuf_read_req     = cnn_on && s.bsel == BBUF && s.op[1];
    lidar_ibuf_write_addr = lidar_addr;
    lidar_ibuf_write_data = lidar_data;
    lidar_ibuf_read_addr  = lidar_addr[5:1];
    lidar_ibuf_write_req  = lidar_on && s.bsel == IBUF && s.op[0];
    lidar_ibuf_read_req   = lidar_on && s.bsel == IBUF && s.op[1];
    lidar_wbuf_write_addr = lidar_addr;
    lidar_wbuf_write_data = lidar_data;
    lidar_wbuf_read_addr  = lidar_addr[5:2];
    lidar_wbuf_write_req  = lidar_on && s.bsel == WBUF && s.op[0];
    lidar_wbuf_read_req   = lidar_on && s.bsel == WBUF && s.op[1];
    lidar_bbuf_write_addr = lidar_addr[3:0];
    lidar_bbuf_write_data = lidar_data;
    lidar_bbuf_read_addr  = lidar_addr[3:1];
    lidar_bbuf_write_req  = lidar_on && s.bsel == BBUF && s.op[0];
    lidar_bbuf_read_req   = lidar_on && s.bsel == BBUF && s.op[1];
  endtask

  task automatic check_ibuf(input ibuf_row_t exp_row, input ibuf_row_t got_row);
    if (got_row !== exp_row) begin
      $display("ERR ibuf_read_data step %0d got 0x%h expected 0x%h", cur_step, got_row, exp_row);
      stop_with_failure();
    end
  endtask

  task automatic check_wbuf(input wbuf_row_t exp_row, input wbuf_row_t got_row);
    if (got_row !== exp_row) begin
      $display("ERR wbuf_read_data step %0d got 0x%h expected 0x%h", cur_step, got_row, exp_row);
      stop_with_failure();
    end
  endtask

  task automatic check_bbuf(input bbuf_row_t exp_row, input bbuf_row_t got_row);
    if (got_row !== exp_row) begin
      $display("ERR bbuf_read_data step %0d got 0x%h expected 0x%h", cur_step, got_row, exp_row);
      stop_with_failure();
    end
  endtask

  task automatic verify_step(input step_t s);
    case (s.bsel)
      IBUF: check_ibuf(s.exp_row[$bits(ibuf_row_t)-1:0], ibuf_read_data);
      WBUF: check_wbuf(s.exp_row, wbuf_read_data);
      default: check_bbuf(s.exp_row[$bits(bbuf_row_t)-1:0], bbuf_read_data);
    endcase
  endtask

  // limit is 4 cycles per entry plus margin for reset
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > steps.size() * 4 + 20) begin
      $display("timeout, the run did not finish after %0d cycles", cycle_count);
      stop_with_failure();
    end
  end

  initial begin
    lcg_state  = 32'h7d25;
    cur_step   = -1;
    for (int b = 0; b < 3; b++) begin
      model_held[b] = '0;
    end
    apply_step('0);
    build_table();
    while (rst !== 1'b0) begin
      @(negedge clk);
    end
    // outputs cleared by reset
    check_ibuf('0, ibuf_read_data);
    check_wbuf('0, wbuf_read_data);
    check_bbuf('0, bbuf_read_data);
    foreach (steps[i]) begin
      cur_step = i;
      apply_step(steps[i]);
      @(negedge clk);
      verify_step(steps[i]);
    end
    apply_step('0);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: all.f
source/buf_pkg.sv
source/client_mux.sv
source/row_buf.sv
source/shared_bufs.sv
dv/tb_clk_gen.sv
dv/shared_bufs_asserts.sv
dv/tb_shared_bufs.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the shared buffer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/100ps \
  --top-module tb_shared_bufs \
  -Mdir obj_dir \
  -f all.f

# the run may end through $fatal, keep the log in both cases
./obj_dir/Vtb_shared_bufs 2>&1 | tee sim.log || true

if grep -q "Some tests failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"
